// ==== src/segre_pkg.sv ====
`default_nettype none

// core-side view of a data memory access
package segre_pkg;

    localparam int WORD_SIZE = 32;

    typedef logic [WORD_SIZE-1:0] word_t;

    // access size, loads are zero-extended
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_e;

    typedef struct packed {
        logic   we;     // store when set
        memop_e memop;
        word_t  addr;   // byte address, aligned to memop
        word_t  wdata;  // store data in the low bytes
    } core_req_t;

endpackage

`default_nettype wire

// ==== src/dcache_pkg.sv ====
`default_nettype none

// cache and backing memory geometry
package dcache_pkg;

    localparam int LANE_SIZE     = 128;             // bits per line
    localparam int LINE_BYTES    = LANE_SIZE / 8;
    localparam int OFFSET_BITS   = 4;               // byte offset inside a line
    localparam int MEM_ADDR_BITS = 12;              // 4 KB of memory
    localparam int MEM_LINES     = (2 ** MEM_ADDR_BITS) / LINE_BYTES;
    localparam int NUM_SETS      = 16;
    localparam int INDEX_BITS    = 4;               // addr[7:4]
    localparam int TAG_BITS      = MEM_ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int MEM_LATENCY   = 10;              // read strobe to ready pulse

    typedef logic [LANE_SIZE-1:0]     line_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [MEM_ADDR_BITS-1:0] line_addr_t;

    // controller to memory, strobes are single cycle
    typedef struct packed {
        logic       rd;
        logic       wr;
        line_addr_t addr;       // refill address
        line_addr_t wr_addr;    // write-back address
        line_t      wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WAIT_MEM
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_memory (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire dcache_pkg::mem_req_t mem_req_i,
    output logic                     data_rdy_o,
    output dcache_pkg::line_t        data_o
);

    import dcache_pkg::*;

    line_t mem [MEM_LINES];

    // read pipeline, one slot per cycle of latency
    logic [MEM_LATENCY-1:0] rd_vld_q;
    line_t                  rd_pipe_q [MEM_LATENCY];

    logic [MEM_ADDR_BITS-OFFSET_BITS-1:0] rd_line;
    logic [MEM_ADDR_BITS-OFFSET_BITS-1:0] wr_line;

    assign rd_line = mem_req_i.addr[MEM_ADDR_BITS-1:OFFSET_BITS];
    assign wr_line = mem_req_i.wr_addr[MEM_ADDR_BITS-1:OFFSET_BITS];

    // memory starts out cleared
    initial begin
        for (int i = 0; i < MEM_LINES; i++) begin
            mem[i] = '0;
        end
    end

    // whole-line write, lands at the edge that samples wr
    always @(posedge clk_i) begin
        if (mem_req_i.wr) begin
            mem[wr_line] <= mem_req_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_vld_q <= '0;
        end else begin
            rd_vld_q <= {rd_vld_q[MEM_LATENCY-2:0], mem_req_i.rd};
        end
    end

    // snapshot taken before any write in the same cycle
    always_ff @(posedge clk_i) begin
        rd_pipe_q[0] <= mem[rd_line];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            rd_pipe_q[i] <= rd_pipe_q[i-1];
        end
    end

    assign data_rdy_o = rd_vld_q[MEM_LATENCY-1];   // one-cycle pulse per read
    assign data_o     = rd_pipe_q[MEM_LATENCY-1];

    // refill and write-back of one line never collide
    a_no_rd_wr_same_line: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(mem_req_i.rd && mem_req_i.wr && (mem_req_i.addr == mem_req_i.wr_addr))
    ) else $error("main_memory: read and write strobed to the same line");

endmodule

`default_nettype wire

// ==== src/dcache_tags.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tags (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire dcache_pkg::index_t index_i,
    input  wire dcache_pkg::tag_t   tag_i,
    input  wire logic              fill_i,
    input  wire logic              store_hit_i,
    output logic                   hit_o,
    output logic                   victim_dirty_o,
    output dcache_pkg::tag_t       victim_tag_o
);

    import dcache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    tag_t                tags_q [NUM_SETS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= 1'b0;   // fresh copy of memory
        end else if (store_hit_i) begin
            dirty_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[index_i] <= tag_i;
        end
    end

    assign hit_o = valid_q[index_i] && (tags_q[index_i] == tag_i);

    // victim info for the write-back on a miss
    assign victim_dirty_o = valid_q[index_i] && dirty_q[index_i];
    assign victim_tag_o   = tags_q[index_i];

    // the controller only writes into a resident line
    a_store_needs_hit: assert property (
        @(posedge clk_i) disable iff (rst_i)
        store_hit_i |-> hit_o
    ) else $error("dcache_tags: store_hit without a tag hit");

endmodule

`default_nettype wire

// ==== src/dcache_data.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data (
    input  wire logic                 clk_i,
    input  wire dcache_pkg::index_t    index_i,
    input  wire logic                 fill_i,
    input  wire logic                 store_hit_i,
    input  wire dcache_pkg::line_t     fill_line_i,
    input  wire segre_pkg::core_req_t  req_i,
    output dcache_pkg::line_t         line_o,
    output segre_pkg::word_t          load_data_o
);

    import dcache_pkg::*;
    import segre_pkg::*;

    line_t lines_q [NUM_SETS];

    logic [OFFSET_BITS-1:0] offset;
    logic [3:0]             size_mask;
    logic [LINE_BYTES-1:0]  byte_en;
    line_t                  store_line;
    line_t                  shifted_line;

    assign offset = req_i.addr[OFFSET_BITS-1:0];
    assign line_o = lines_q[index_i];

    always_comb begin
        case (req_i.memop)
            BYTE:    size_mask = 4'b0001;
            HALF:    size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    // place the store bytes at their offset in the line
    assign byte_en    = LINE_BYTES'(size_mask) << offset;
    assign store_line = line_t'(req_i.wdata) << {offset, 3'b000};

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lines_q[index_i] <= fill_line_i;
        end else if (store_hit_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (byte_en[b]) begin
                    lines_q[index_i][8*b +: 8] <= store_line[8*b +: 8];
                end
            end
        end
    end

    // load path, little endian and zero-extended
    assign shifted_line = line_o >> {offset, 3'b000};

    always_comb begin
        case (req_i.memop)
            BYTE:    load_data_o = {24'b0, shifted_line[7:0]};
            HALF:    load_data_o = {16'b0, shifted_line[15:0]};
            default: load_data_o = shifted_line[WORD_SIZE-1:0];
        endcase
    end

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 req_valid_i,
    input  wire segre_pkg::core_req_t  req_i,
    input  wire logic                 hit_i,
    input  wire logic                 victim_dirty_i,
    input  wire dcache_pkg::tag_t      victim_tag_i,
    input  wire dcache_pkg::line_t     victim_line_i,
    input  wire segre_pkg::word_t      load_data_i,
    input  wire logic                 data_rdy_i,
    output logic                      busy_o,
    output logic                      done_o,
    output segre_pkg::word_t          rdata_o,
    output logic                      fill_o,
    output logic                      store_hit_o,
    output segre_pkg::core_req_t      held_req_o,
    output dcache_pkg::mem_req_t      mem_req_o
);

    import segre_pkg::*;
    import dcache_pkg::*;

    ctrl_state_e state_q, state_d;
    core_req_t   req_q;
    word_t       rdata_q;
    logic        done_q;
    logic        lookup_hit;
    logic        lookup_miss;

    assign busy_o      = (state_q != IDLE);
    assign lookup_hit  = (state_q == LOOKUP) && hit_i;
    assign lookup_miss = (state_q == LOOKUP) && !hit_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (req_valid_i) state_d = LOOKUP;
            LOOKUP:   state_d = hit_i ? IDLE : WAIT_MEM;
            WAIT_MEM: if (data_rdy_i) state_d = LOOKUP;    // retry after refill
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= lookup_hit;
        end
    end

    // request held for the whole access
    always_ff @(posedge clk_i) begin
        if (req_valid_i && !busy_o) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_hit && !req_q.we) begin
            rdata_q <= load_data_i;
        end
    end

    assign done_o      = done_q;
    assign rdata_o     = rdata_q;
    assign held_req_o  = req_q;
    assign store_hit_o = lookup_hit && req_q.we;
    assign fill_o      = (state_q == WAIT_MEM) && data_rdy_i;

    // refill read, plus write-back of a dirty victim in the same cycle
    always_comb begin
        mem_req_o.rd      = lookup_miss;
        mem_req_o.wr      = lookup_miss && victim_dirty_i;
        mem_req_o.addr    = {req_q.addr[MEM_ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        mem_req_o.wr_addr = {victim_tag_i, req_q.addr[OFFSET_BITS +: INDEX_BITS],
                             {OFFSET_BITS{1'b0}}};
        mem_req_o.wdata   = victim_line_i;
    end

    a_no_req_while_busy: assert property (
        @(posedge clk_i) disable iff (rst_i)
        busy_o |-> !req_valid_i
    ) else $error("dcache_ctrl: request strobed while busy");

    a_req_aligned: assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_valid_i |-> (req_i.memop == BYTE)
                     || (req_i.memop == HALF && !req_i.addr[0])
                     || (req_i.memop == WORD && req_i.addr[1:0] == 2'b00)
    ) else $error("dcache_ctrl: misaligned or bad-size request");

    // only 4 KB behind the cache
    a_req_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_valid_i |-> (req_i.addr[WORD_SIZE-1:MEM_ADDR_BITS] == '0)
    ) else $error("dcache_ctrl: request address outside memory");

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                req_valid_i,
    input  wire segre_pkg::core_req_t req_i,
    output logic                     busy_o,
    output logic                     done_o,
    output segre_pkg::word_t         rdata_o
);

    import segre_pkg::*;
    import dcache_pkg::*;

    core_req_t held_req;
    mem_req_t  mem_req;
    line_t     victim_line;
    line_t     mem_line;
    word_t     load_data;
    tag_t      victim_tag;
    index_t    index;
    tag_t      tag;
    logic      hit;
    logic      victim_dirty;
    logic      fill;
    logic      store_hit;
    logic      data_rdy;

    // set and tag of the access in flight
    assign index = held_req.addr[OFFSET_BITS +: INDEX_BITS];
    assign tag   = held_req.addr[MEM_ADDR_BITS-1 -: TAG_BITS];

    dcache_ctrl dcache_ctrl_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .load_data_i    (load_data),
        .data_rdy_i     (data_rdy),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .rdata_o        (rdata_o),
        .fill_o         (fill),
        .store_hit_o    (store_hit),
        .held_req_o     (held_req),
        .mem_req_o      (mem_req)
    );

    dcache_tags dcache_tags_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .index_i        (index),
        .tag_i          (tag),
        .fill_i         (fill),
        .store_hit_i    (store_hit),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data dcache_data_i (
        .clk_i       (clk_i),
        .index_i     (index),
        .fill_i      (fill),
        .store_hit_i (store_hit),
        .fill_line_i (mem_line),    // refill straight from memory
        .req_i       (held_req),
        .line_o      (victim_line),
        .load_data_o (load_data)
    );

    main_memory main_memory_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mem_req_i  (mem_req),
        .data_rdy_o (data_rdy),
        .data_o     (mem_line)
    );

endmodule

`default_nettype wire

// ==== bench/mem_subsystem_ref.svh ====
`ifndef MEM_SUBSYSTEM_REF_SVH
`define MEM_SUBSYSTEM_REF_SVH

// byte-wide shadow of the 4 KB behind the cache
logic [7:0] shadow_mem [4096];

initial begin
    for (int i = 0; i < 4096; i++) begin
        shadow_mem[i] = 8'h00;
    end
end

function automatic int access_bytes(input memop_e memop);
    case (memop)
        BYTE:    return 1;
        HALF:    return 2;
        default: return 4;
    endcase
endfunction

// little endian store of the low bytes of wdata
function automatic void ref_store(input core_req_t req);
    int n;
    n = access_bytes(req.memop);
    for (int i = 0; i < n; i++) begin
        shadow_mem[req.addr[11:0] + i] = req.wdata[8*i +: 8];
    end
endfunction

function automatic word_t ref_load(input core_req_t req);
    word_t value;
    int    n;
    value = '0;     // upper bytes stay zero
    n = access_bytes(req.memop);
    for (int i = 0; i < n; i++) begin
        value[8*i +: 8] = shadow_mem[req.addr[11:0] + i];
    end
    return value;
endfunction

`endif

// ==== bench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    import segre_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic      clk_i;
    logic      rst_i;
    logic      req_valid_i;
    core_req_t req_i;
    logic      busy_o;
    logic      done_o;
    word_t     rdata_o;

    integer    seed = 32'hfc97_0743;
    core_req_t pending_req;     // request the next done_o belongs to
    logic      in_flight;
    logic      aborted;
    int        errors;
    int        errors_at_start;
    int        tests_ok;
    int        tests_failing;
    int        issued_count;
    int        done_count;

    `include "mem_subsystem_ref.svh"

    mem_subsystem mem_subsystem_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // compare process samples outputs mid-cycle
    always @(negedge clk_i) begin
        if (!rst_i && done_o) begin
            done_count++;
            if (!in_flight) begin
                $display("error at %0t: done_o pulsed with no request outstanding", $time);
                errors++;
            end else if (pending_req.we) begin
                ref_store(pending_req);
            end else if (rdata_o !== ref_load(pending_req)) begin
                $display("mismatch at %0t: rdata_o (addr %h) expected %h got %h",
                         $time, pending_req.addr, ref_load(pending_req), rdata_o);
                errors++;
            end
            in_flight = 1'b0;
        end else if (!rst_i && in_flight && !busy_o) begin
            $display("error at %0t: busy_o went low before done_o", $time);
            errors++;
        end
    end

    // wait for a free cache, strobe one request, wait for its completion
    task automatic issue_req(input logic we, input memop_e op, input word_t addr,
                             input word_t wdata);
        core_req_t req;
        int        cycles;
        req.we    = we;
        req.memop = op;
        req.addr  = addr;
        req.wdata = wdata;
        if (!aborted) begin
            cycles = 0;
            @(negedge clk_i);
            while (busy_o && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk_i);
                cycles++;
            end
            if (busy_o) begin
                $display("error at %0t: cache never became free for a request", $time);
                errors++;
                aborted = 1'b1;
            end else begin
                @(posedge clk_i);
                req_valid_i <= 1'b1;
                req_i       <= req;
                pending_req = req;
                @(posedge clk_i);
                req_valid_i <= 1'b0;
                in_flight = 1'b1;
                issued_count++;
                cycles = 0;
                @(negedge clk_i);
                while (!done_o && cycles < TIMEOUT_CYCLES) begin
                    @(negedge clk_i);
                    cycles++;
                end
                if (!done_o) begin
                    $display("error at %0t: no done_o for request to %h", $time, addr);
                    errors++;
                    in_flight = 1'b0;
                    aborted = 1'b1;
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_failing++;
            $display("%s: FAILED, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        memop_e op;
        word_t  addr;
        logic   we;
        rst_i = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        pending_req = '0;
        in_flight = 1'b0;
        aborted = 1'b0;
        errors = 0;
        errors_at_start = 0;
        tests_ok = 0;
        tests_failing = 0;
        issued_count = 0;
        done_count = 0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);

        if (busy_o !== 1'b0) begin
            $display("mismatch at %0t: busy_o expected 0 got %b", $time, busy_o);
            errors++;
        end
        if (done_o !== 1'b0) begin
            $display("mismatch at %0t: done_o expected 0 got %b", $time, done_o);
            errors++;
        end
        issue_req(1'b0, WORD, 32'h000, '0);
        issue_req(1'b0, BYTE, 32'h1f7, '0);
        issue_req(1'b0, HALF, 32'hffe, '0);
        end_test("test 1 reset state");

        issue_req(1'b1, WORD, 32'h100, 32'hdead_beef);
        issue_req(1'b0, WORD, 32'h100, '0);
        end_test("test 2 word store and load");

        // upper wdata bits must never reach memory
        for (int i = 15; i >= 0; i--) begin
            issue_req(1'b1, BYTE, 32'h240 + i, 32'hcafe_0000 + i * 37);
        end
        issue_req(1'b1, HALF, 32'h242, 32'h1234_8001);
        issue_req(1'b1, HALF, 32'h24c, 32'h5678_f00e);
        for (int i = 0; i < 16; i++) begin
            issue_req(1'b0, BYTE, 32'h240 + i, '0);
        end
        for (int i = 0; i < 16; i += 2) begin
            issue_req(1'b0, HALF, 32'h240 + i, '0);
        end
        for (int i = 0; i < 16; i += 4) begin
            issue_req(1'b0, WORD, 32'h240 + i, '0);
        end
        end_test("test 3 byte and half-word merging");

        // all three lines map to set 5
        issue_req(1'b1, WORD, 32'h358, 32'h0bad_f00d);
        issue_req(1'b0, WORD, 32'h058, '0);
        issue_req(1'b1, HALF, 32'h15a, 32'h0000_7777);
        issue_req(1'b0, WORD, 32'h358, '0);
        issue_req(1'b0, HALF, 32'h15a, '0);
        end_test("test 4 write-back and refill");

        for (int n = 0; n < 300; n++) begin
            op = memop_e'($unsigned($random(seed)) % 3);
            addr = $unsigned($random(seed)) & 32'h3ff;     // 64 lines
            if (op == HALF) begin
                addr[0] = 1'b0;
            end
            if (op == WORD) begin
                addr[1:0] = 2'b00;
            end
            we = $random(seed) & 1;
            issue_req(we, op, addr, $random(seed));
        end
        end_test("test 5 random traffic");

        repeat (4) @(posedge clk_i);    // room for a stray pulse
        if (done_count != issued_count) begin
            $display("mismatch at %0t: done_o pulses expected %0d got %0d",
                     $time, issued_count, done_count);
            errors++;
        end
        end_test("test 6 one completion per request");

        $display("summary: %0d tests ok, %0d tests failing, %0d errors",
                 tests_ok, tests_failing, errors);
        if (errors == 0 && tests_failing == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_subsystem.f ====
+incdir+bench
src/segre_pkg.sv
src/dcache_pkg.sv
src/main_memory.sv
src/dcache_tags.sv
src/dcache_data.sv
src/dcache_ctrl.sv
src/mem_subsystem.sv
bench/mem_subsystem_tb.sv
